// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dmem
RTL_TOP   ?= dmem_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
common/dmem_pkg.sv
common/bank_req_if.sv
common/load_info_if.sv
src/dmem_decode.sv
sram/sram_bank_model.sv
sram/sp_ram_bank.sv
src/load_align.sv
src/dmem_top.sv
dv/tb_dmem.sv

// File: common/bank_req_if.sv
// decoded request into the bank array, one access per cycle with en high
interface bank_req_if;

  logic                  en;
  logic                  we;
  dmem_pkg::bank_idx_t   bank;
  dmem_pkg::word_addr_t  waddr;
  dmem_pkg::word_t       wdata;
  dmem_pkg::be_t         be;

  modport master (
    output en,
    output we,
    output bank,
    output waddr,
    output wdata,
    output be
  );

  modport slave (
    input  en,
    input  we,
    input  bank,
    input  waddr,
    input  wdata,
    input  be
  );

endinterface

// File: common/dmem_pkg.sv
package dmem_pkg;

  // memory geometry
  localparam int NUM_BANKS   = 4;
  localparam int BANK_WORDS  = 256;
  localparam int BANK_IDX_W  = 2;
  localparam int WORD_ADDR_W = 8;
  // bank index, word address and two offset bits
  localparam int BYTE_ADDR_W = 12;

  // access size encoding
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef logic [31:0]            word_t;
  typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [BANK_IDX_W-1:0]  bank_idx_t;
  typedef logic [3:0]             be_t;
  typedef logic [1:0]             offset_t;
  typedef logic [1:0]             size_t;

endpackage

// File: common/load_info_if.sv
// attributes of the request accepted in the previous cycle
interface load_info_if;

  logic               valid;
  logic               is_err;
  dmem_pkg::offset_t  offset;
  dmem_pkg::size_t    size;
  logic               sign;

  modport master (
    output valid,
    output is_err,
    output offset,
    output size,
    output sign
  );

  modport slave (
    input  valid,
    input  is_err,
    input  offset,
    input  size,
    input  sign
  );

endinterface

// File: dv/tb_dmem.sv
module tb_dmem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 10;
  localparam int N_WORDS      = 16;
  localparam int N_PART       = 8;
  localparam int N_MIS        = 4;
  // one cycle per request or idle slot over all tests
  localparam int TEST_CYCLES  = RESET_CYCLES + IDLE_CYCLES + (3 * N_WORDS + 1)
                              + (4 * N_PART + 1) + (12 * N_PART + 1)
                              + (N_WORDS + 1) + (4 * N_MIS + 1);
  localparam int TIMEOUT_NS   = 2 * TEST_CYCLES * CLK_PERIOD + 200;

  logic                  clk_i;
  logic                  rstn_i;
  logic                  req_i;
  logic                  we_i;
  dmem_pkg::byte_addr_t  addr_i;
  dmem_pkg::size_t       size_i;
  logic                  sign_i;
  dmem_pkg::word_t       wdata_i;
  logic                  rvalid_o;
  dmem_pkg::word_t       rdata_o;
  logic                  err_o;

  integer seed;
  int     errors;
  int     checks;

  // byte-wide reference memory over the whole address space
  logic [7:0]            ref_mem [1 << dmem_pkg::BYTE_ADDR_W];
  dmem_pkg::byte_addr_t  addr_list [N_WORDS];
  dmem_pkg::byte_addr_t  part_list [N_PART];

  // response expected from the request issued in the previous cycle
  logic                  exp_rvalid;
  logic                  exp_err;
  dmem_pkg::word_t       exp_rdata;

  dmem_top dmem_top_inst (
    .clk_i    ( clk_i    ),
    .rstn_i   ( rstn_i   ),
    .req_i    ( req_i    ),
    .we_i     ( we_i     ),
    .addr_i   ( addr_i   ),
    .size_i   ( size_i   ),
    .sign_i   ( sign_i   ),
    .wdata_i  ( wdata_i  ),
    .rvalid_o ( rvalid_o ),
    .rdata_o  ( rdata_o  ),
    .err_o    ( err_o    )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_word(input string name, input dmem_pkg::word_t got,
                            input dmem_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic is_misaligned(input dmem_pkg::size_t size,
                                         input dmem_pkg::byte_addr_t addr);
    if (size == dmem_pkg::SIZE_BYTE) begin
      return 1'b0;
    end else if (size == dmem_pkg::SIZE_HALF) begin
      return addr[0];
    end
    return addr[1:0] != 2'b00;
  endfunction

  // little endian bytes from the reference memory
  function automatic dmem_pkg::word_t read_ref_value(input dmem_pkg::byte_addr_t addr,
                                                     input dmem_pkg::size_t size,
                                                     input logic sign);
    dmem_pkg::word_t v;
    v = '0;
    for (int b = 0; b < 4; b++) begin
      if (b == 0 || (b == 1 && size != dmem_pkg::SIZE_BYTE) || size == dmem_pkg::SIZE_WORD) begin
        v[8*b +: 8] = ref_mem[addr + dmem_pkg::byte_addr_t'(b)];
      end
    end
    if (sign && size == dmem_pkg::SIZE_BYTE && v[7]) begin
      v[31:8] = '1;
    end
    if (sign && size == dmem_pkg::SIZE_HALF && v[15]) begin
      v[31:16] = '1;
    end
    return v;
  endfunction

  task automatic write_ref_bytes(input dmem_pkg::byte_addr_t addr, input dmem_pkg::size_t size,
                                 input dmem_pkg::word_t wdata);
    int n;
    n = (size == dmem_pkg::SIZE_BYTE) ? 1 : (size == dmem_pkg::SIZE_HALF) ? 2 : 4;
    for (int b = 0; b < n; b++) begin
      ref_mem[addr + dmem_pkg::byte_addr_t'(b)] = wdata[8*b +: 8];
    end
  endtask

  // response to the request accepted at the last rising edge
  task automatic compare_response();
    check_flag("rvalid_o", rvalid_o, exp_rvalid);
    check_flag("err_o", err_o, exp_err);
    check_word("rdata_o", rdata_o, exp_rdata);
  endtask

  task automatic issue_request(input logic we, input dmem_pkg::byte_addr_t addr,
                               input dmem_pkg::size_t size, input logic sign,
                               input dmem_pkg::word_t wdata);
    logic mis;
    @(negedge clk_i);
    compare_response();
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    size_i  = size;
    sign_i  = sign;
    wdata_i = wdata;
    mis = is_misaligned(size, addr);
    exp_rvalid = !we && !mis;
    exp_err    = mis;
    exp_rdata  = exp_rvalid ? read_ref_value(addr, size, sign) : '0;
    if (we && !mis) begin
      write_ref_bytes(addr, size, wdata);
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    compare_response();
    req_i      = 1'b0;
    exp_rvalid = 1'b0;
    exp_err    = 1'b0;
    exp_rdata  = '0;
  endtask

  task automatic idle_after_reset();
    repeat (IDLE_CYCLES) idle_cycle();
  endtask

  task automatic word_write_read();
    dmem_pkg::word_t r;
    for (int i = 0; i < N_WORDS; i++) begin
      r = $random(seed);
      // bank follows i to cover every bank
      addr_list[i] = {dmem_pkg::bank_idx_t'(i), r[7:0], 2'b00};
      issue_request(1'b1, addr_list[i], dmem_pkg::SIZE_WORD, 1'b0, $random(seed));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      issue_request(1'b0, addr_list[i], dmem_pkg::SIZE_WORD, 1'b0, '0);
      idle_cycle();
    end
    idle_cycle();
  endtask

  task automatic partial_writes();
    dmem_pkg::word_addr_t wa;
    dmem_pkg::byte_addr_t a;
    dmem_pkg::word_t      pattern;
    for (int i = 0; i < N_PART; i++) begin
      wa = dmem_pkg::word_addr_t'(224 + i);
      a  = {dmem_pkg::bank_idx_t'(i), wa, 2'b00};
      part_list[i] = a;
      pattern = 32'h8F70_E1C3 + 32'h0101_0101 * dmem_pkg::word_t'(i);
      issue_request(1'b1, a, dmem_pkg::SIZE_WORD, 1'b0, pattern);
      issue_request(1'b1, a + dmem_pkg::byte_addr_t'(i % 4), dmem_pkg::SIZE_BYTE, 1'b0,
                    $random(seed));
      // half goes to the other half of the word from the byte
      issue_request(1'b1, a + dmem_pkg::byte_addr_t'((i % 4 < 2) ? 2 : 0),
                    dmem_pkg::SIZE_HALF, 1'b0, $random(seed));
      issue_request(1'b0, a, dmem_pkg::SIZE_WORD, 1'b0, '0);
    end
    idle_cycle();
  endtask

  task automatic signed_loads();
    dmem_pkg::byte_addr_t a;
    for (int i = 0; i < N_PART; i++) begin
      a = part_list[i];
      for (int off = 0; off < 4; off++) begin
        for (int s = 0; s < 2; s++) begin
          issue_request(1'b0, a + dmem_pkg::byte_addr_t'(off), dmem_pkg::SIZE_BYTE, 1'(s), '0);
        end
      end
      for (int off = 0; off < 4; off += 2) begin
        for (int s = 0; s < 2; s++) begin
          issue_request(1'b0, a + dmem_pkg::byte_addr_t'(off), dmem_pkg::SIZE_HALF, 1'(s), '0);
        end
      end
    end
    idle_cycle();
  endtask

  // a new read every cycle with banks 0..3 in turn
  task automatic back_to_back_reads();
    for (int i = 0; i < N_WORDS; i++) begin
      issue_request(1'b0, addr_list[i], dmem_pkg::SIZE_WORD, 1'b0, '0);
    end
    idle_cycle();
  endtask

  task automatic misaligned_requests();
    dmem_pkg::byte_addr_t a;
    dmem_pkg::word_t      r;
    for (int i = 0; i < N_MIS; i++) begin
      a = addr_list[i];
      r = $random(seed);
      issue_request(1'b0, a + dmem_pkg::byte_addr_t'(1 + 2 * int'(r[0])),
                    dmem_pkg::SIZE_HALF, r[1], '0);
      issue_request(1'b0, a + dmem_pkg::byte_addr_t'(int'(r[3:2]) % 3 + 1),
                    dmem_pkg::SIZE_WORD, 1'b0, '0);
      if (i % 2 == 0) begin
        issue_request(1'b1, a + dmem_pkg::byte_addr_t'(2), dmem_pkg::SIZE_WORD, 1'b0,
                      $random(seed));
      end else begin
        issue_request(1'b1, a + dmem_pkg::byte_addr_t'(1), dmem_pkg::SIZE_HALF, 1'b0,
                      $random(seed));
      end
      // word must be untouched by the write above
      issue_request(1'b0, a, dmem_pkg::SIZE_WORD, 1'b0, '0);
    end
    idle_cycle();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed       = 32'h0520114a;
    errors     = 0;
    checks     = 0;
    clk_i      = 1'b0;
    rstn_i     = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    size_i     = dmem_pkg::SIZE_WORD;
    sign_i     = 1'b0;
    wdata_i    = '0;
    exp_rvalid = 1'b0;
    exp_err    = 1'b0;
    exp_rdata  = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rstn_i = 1'b1;

    idle_after_reset();
    word_write_read();
    partial_writes();
    signed_loads();
    back_to_back_reads();
    misaligned_requests();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sram/sp_ram_bank.sv
module sp_ram_bank #(
  parameter int NUM_BANKS  = dmem_pkg::NUM_BANKS,
  parameter int BANK_WORDS = dmem_pkg::BANK_WORDS
) (
  input  logic             clk_i,
  input  logic             rstn_i,
  bank_req_if.slave        req_i,
  output dmem_pkg::word_t  rdata_o
);

  localparam int N_LEVELS = $clog2(NUM_BANKS);

  logic [N_LEVELS-1:0] bank_sel;
  logic [N_LEVELS-1:0] bank_q;

  // heap-ordered tree, root at 0, bank outputs at the leaves
  dmem_pkg::word_t tree [2*NUM_BANKS-1];

  assign bank_sel = N_LEVELS'(req_i.bank);

  genvar i;
  generate
    for (i = 0; i < NUM_BANKS; i++) begin : g_bank
      logic bank_en;

      assign bank_en = req_i.en && (bank_sel == i);

      sram_bank_model #(
        .WORDS ( BANK_WORDS )
      ) bank_inst (
        .clk_i   ( clk_i                 ),
        .en_i    ( bank_en               ),
        .we_i    ( req_i.we              ),
        .addr_i  ( req_i.waddr           ),
        .wdata_i ( req_i.wdata           ),
        .be_i    ( req_i.be              ),
        .rdata_o ( tree[NUM_BANKS-1+i]   )
      );
    end
  endgenerate

  // index of the bank read in the previous cycle
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      bank_q <= '0;
    end else if (req_i.en) begin
      bank_q <= bank_sel;
    end
  end

  // level j steered by index bit N_LEVELS-1-j, msb at the root
  genvar j, k;
  generate
    for (j = 0; j < N_LEVELS; j++) begin : g_level
      for (k = 0; k < 2**j; k++) begin : g_node
        assign tree[2**j-1+k] = bank_q[N_LEVELS-1-j] ? tree[2*(2**j-1+k)+2]
                                                     : tree[2*(2**j-1+k)+1];
      end
    end
  endgenerate

  assign rdata_o = tree[0];

endmodule

// File: sram/sram_bank_model.sv
module sram_bank_model #(
  parameter int WORDS = dmem_pkg::BANK_WORDS
) (
  input  logic                  clk_i,
  input  logic                  en_i,
  input  logic                  we_i,
  input  dmem_pkg::word_addr_t  addr_i,
  input  dmem_pkg::word_t       wdata_i,
  input  dmem_pkg::be_t         be_i,
  output dmem_pkg::word_t       rdata_o
);

  dmem_pkg::word_t mem [WORDS];

  // single port, write only touches enabled bytes
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: src/dmem_decode.sv
module dmem_decode (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  dmem_pkg::byte_addr_t  addr_i,
  input  dmem_pkg::size_t       size_i,
  input  logic                  sign_i,
  input  dmem_pkg::word_t       wdata_i,
  bank_req_if.master            bank_o,
  load_info_if.master           info_o
);

  dmem_pkg::offset_t offset;
  logic              misaligned;

  // address fields: bank | word | offset
  assign offset = addr_i[1:0];

  always_comb begin
    case (size_i)
      dmem_pkg::SIZE_BYTE: misaligned = 1'b0;
      dmem_pkg::SIZE_HALF: misaligned = offset[0];
      default:             misaligned = |offset;
    endcase
  end

  assign bank_o.en    = req_i & ~misaligned;
  assign bank_o.we    = we_i;
  assign bank_o.bank  = addr_i[dmem_pkg::BYTE_ADDR_W-1 -: dmem_pkg::BANK_IDX_W];
  assign bank_o.waddr = addr_i[dmem_pkg::WORD_ADDR_W+1:2];

  // byte enables and lane replication
  always_comb begin
    case (size_i)
      dmem_pkg::SIZE_BYTE: begin
        bank_o.be    = 4'b0001 << offset;
        bank_o.wdata = {4{wdata_i[7:0]}};
      end
      dmem_pkg::SIZE_HALF: begin
        bank_o.be    = 4'b0011 << offset;
        bank_o.wdata = {2{wdata_i[15:0]}};
      end
      default: begin
        bank_o.be    = 4'b1111;
        bank_o.wdata = wdata_i;
      end
    endcase
  end

  // load info for the result stage, a read or an error
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      info_o.valid  <= 1'b0;
      info_o.is_err <= 1'b0;
      info_o.offset <= '0;
      info_o.size   <= '0;
      info_o.sign   <= 1'b0;
    end else begin
      info_o.valid  <= req_i & (~we_i | misaligned);
      info_o.is_err <= req_i & misaligned;
      info_o.offset <= offset;
      info_o.size   <= size_i;
      info_o.sign   <= sign_i;
    end
  end

endmodule

// File: src/dmem_top.sv
module dmem_top (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  dmem_pkg::byte_addr_t  addr_i,
  input  dmem_pkg::size_t       size_i,
  input  logic                  sign_i,
  input  dmem_pkg::word_t       wdata_i,
  output logic                  rvalid_o,
  output dmem_pkg::word_t       rdata_o,
  output logic                  err_o
);

  bank_req_if  bank_req ();
  load_info_if load_info ();

  dmem_pkg::word_t bank_rdata;

  dmem_decode decode_inst (
    .clk_i   ( clk_i     ),
    .rstn_i  ( rstn_i    ),
    .req_i   ( req_i     ),
    .we_i    ( we_i      ),
    .addr_i  ( addr_i    ),
    .size_i  ( size_i    ),
    .sign_i  ( sign_i    ),
    .wdata_i ( wdata_i   ),
    .bank_o  ( bank_req  ),
    .info_o  ( load_info )
  );

  sp_ram_bank ram_inst (
    .clk_i   ( clk_i      ),
    .rstn_i  ( rstn_i     ),
    .req_i   ( bank_req   ),
    .rdata_o ( bank_rdata )
  );

  load_align align_inst (
    .rdata_i  ( bank_rdata ),
    .info_i   ( load_info  ),
    .rvalid_o ( rvalid_o   ),
    .rdata_o  ( rdata_o    ),
    .err_o    ( err_o      )
  );

endmodule

// File: src/load_align.sv
module load_align (
  input  dmem_pkg::word_t  rdata_i,
  load_info_if.slave       info_i,
  output logic             rvalid_o,
  output dmem_pkg::word_t  rdata_o,
  output logic             err_o
);

  dmem_pkg::word_t shifted;
  dmem_pkg::word_t extended;

  // move the addressed lane down to bit 0
  assign shifted = rdata_i >> {info_i.offset, 3'b000};

  always_comb begin
    case (info_i.size)
      dmem_pkg::SIZE_BYTE: begin
        extended = {{24{info_i.sign & shifted[7]}}, shifted[7:0]};
      end
      dmem_pkg::SIZE_HALF: begin
        extended = {{16{info_i.sign & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        extended = shifted;
      end
    endcase
  end

  assign rvalid_o = info_i.valid & ~info_i.is_err;
  assign err_o    = info_i.valid & info_i.is_err;

  // keep the bus quiet between responses
  assign rdata_o  = rvalid_o ? extended : '0;

endmodule
